/* build.f */
lcm_pkg.sv
scalar_gcd.sv
scalar_lcm.sv
vector_lcm.sv
lcm_regs.sv
lcm_top.sv
tb_checker.sv
tb_top.sv

/* Makefile */
# Verilator build, run, lint and clean for the LCM accelerator

VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= lcm_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert
RTL_SRCS  ?= lcm_pkg.sv scalar_gcd.sv scalar_lcm.sv vector_lcm.sv lcm_regs.sv lcm_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_top.sv */
// Testbench top for the vector LCM accelerator
// Clock, reset, Wishbone bus tasks and the stimulus table
// Runs every table row and prints per test lines and totals
`timescale 1ns/1ps

module tb_top;

  import lcm_pkg::*;

  localparam int NROWS   = 8;
  localparam int ACK_TO  = 20;
  localparam int DONE_TO = 2000;

  logic             CLK;
  logic             RST;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_dat_w;
  logic [3:0]       wb_sel;
  logic             wb_ack;
  logic [WB_DW-1:0] wb_dat_r;
  int               errors;
  int               checks;
  int               cycle;
  int               failed_tests;
  bit               timed_out;

  // Stimulus table, one row per test
  string            row_name [NROWS];
  logic [31:0]      row_size [NROWS];
  logic [31:0]      row_mod  [NROWS];
  logic [31:0]      row_a    [NROWS][VEC_MAX];
  logic [31:0]      row_b    [NROWS][VEC_MAX];

  lcm_top u_lcm_top (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r)
  );

  tb_checker u_checker (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .errors   (errors),
    .checks   (checks)
  );

  ////////////////////
  // Clock
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  ////////////////////
  // Bus tasks
  task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
    int waited;
    rdata = '0;
    if (!timed_out) begin
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      waited   = 0;
      do begin
        @(posedge CLK);
        #1;
        waited++;
      end while (!wb_ack && (waited < ACK_TO));
      if (!wb_ack) begin
        $display("Timeout: the wait for ack at address 0x%02h timed out", adr);
        timed_out = 1'b1;
      end
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      // One idle cycle between requests
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data);
    logic [WB_DW-1:0] unused_rd;
    bus_access(1'b1, adr, data, unused_rd);
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
    bus_access(1'b0, adr, '0, data);
  endtask

  // Poll STATUS until the done bit
  task automatic wait_done();
    int               t0;
    logic [WB_DW-1:0] st;
    t0 = cycle;
    st = '0;
    while (!timed_out && !st[1]) begin
      if (cycle - t0 > DONE_TO) begin
        $display("Timeout: the wait for done timed out after %0d cycles", DONE_TO);
        timed_out = 1'b1;
      end else begin
        wb_read(ADDR_STATUS, st);
      end
    end
  endtask

  ////////////////////
  // Tests
  task automatic check_registers();
    logic [WB_DW-1:0] rd;
    logic [WB_AW-1:0] holes [7] = '{8'h00, 8'h04, 8'h18, 8'h28, 8'h38, 8'h40, 8'hff};
    wb_read(ADDR_STATUS, rd);
    wb_write(ADDR_MODULO, 32'hbeef_1234);
    wb_write(ADDR_SIZE, 32'h5);
    // Upper half set so truncation shows
    for (int i = 0; i < VEC_MAX; i++) begin
      wb_write(ADDR_A_BASE + 8'(i), {16'hc3c3, ADDR_A_BASE + 8'(i), ~(ADDR_A_BASE + 8'(i))});
      wb_write(ADDR_B_BASE + 8'(i), {16'h5a5a, ~(ADDR_B_BASE + 8'(i)), ADDR_B_BASE + 8'(i)});
    end
    wb_read(ADDR_MODULO, rd);
    wb_read(ADDR_SIZE, rd);
    for (int i = 0; i < VEC_MAX; i++) begin
      wb_read(ADDR_A_BASE + 8'(i), rd);
      wb_read(ADDR_B_BASE + 8'(i), rd);
    end
    for (int i = 0; i < 7; i++) begin
      wb_read(holes[i], rd);
    end
    wb_read(ADDR_STATUS, rd);
  endtask

  task automatic run_row(input int r);
    logic [WB_DW-1:0] rd;
    wb_write(ADDR_MODULO, row_mod[r]);
    wb_write(ADDR_SIZE, row_size[r]);
    for (int i = 0; i < VEC_MAX; i++) begin
      wb_write(ADDR_A_BASE + 8'(i), row_a[r][i]);
      wb_write(ADDR_B_BASE + 8'(i), row_b[r][i]);
    end
    wb_write(ADDR_CTRL, 32'h1);
    wait_done();
    // All entries, so untouched ones are checked too
    for (int i = 0; i < VEC_MAX; i++) begin
      wb_read(ADDR_RES_BASE + 8'(i), rd);
    end
  endtask

  task automatic fill_table();
    row_name[0] = "coprime and shared factors";
    row_size[0] = 8;
    row_mod[0]  = 0;
    row_a[0]    = '{4, 3, 12, 7, 21, 100, 17, 9};
    row_b[0]    = '{6, 5, 18, 7, 6, 75, 34, 28};
    row_name[1] = "modulus 97";
    row_size[1] = 8;
    row_mod[1]  = 97;
    row_a[1]    = '{1000, 65535, 255, 360, 48, 1001, 4096, 999};
    row_b[1]    = '{770, 3, 256, 84, 180, 143, 6, 37};
    row_name[2] = "modulus of one";
    row_size[2] = 4;
    row_mod[2]  = 1;
    row_a[2]    = '{5, 6, 8, 9, 10, 11, 12, 13};
    row_b[2]    = '{7, 4, 12, 3, 15, 22, 9, 26};
    row_name[3] = "edge operands";
    row_size[3] = 8;
    row_mod[3]  = 0;
    row_a[3]    = '{0, 5, 0, 65535, 65535, 65521, 1, 40000};
    row_b[3]    = '{5, 0, 0, 65535, 65534, 65519, 1, 1};
    row_name[4] = "size zero";
    row_size[4] = 0;
    row_mod[4]  = 7;
    row_a[4]    = '{12, 2, 3, 4, 5, 6, 7, 8};
    row_b[4]    = '{18, 9, 10, 11, 12, 13, 14, 15};
    row_name[5] = "size past the buffer";
    row_size[5] = 13;
    row_mod[5]  = 1000;
    row_a[5]    = '{360, 1234, 999, 65535, 7, 48, 30030, 512};
    row_b[5]    = '{1024, 4321, 37, 2, 9, 64, 510, 768};
    // Random rows, the last one reduced
    for (int r = 6; r < NROWS; r++) begin
      row_name[r] = (r == 6) ? "random, no modulus" : "random with modulus";
      row_size[r] = $urandom % 9;
      row_mod[r]  = (r == 6) ? 32'h0 : ($urandom & 32'hffff);
      for (int i = 0; i < VEC_MAX; i++) begin
        row_a[r][i] = $urandom & 32'hffff;
        row_b[r][i] = $urandom & 32'hffff;
      end
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (timed_out || (errors != err_before)) begin
      failed_tests++;
      $display("test %0d (%s): FAIL, %0d mismatches", num, name, errors - err_before);
    end else begin
      $display("test %0d (%s): ok", num, name);
    end
  endtask

  ////////////////////
  // Main sequence
  initial begin
    int err_before;
    void'($urandom(32'h8cf8));
    RST          = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    wb_sel       = 4'hf;
    timed_out    = 1'b0;
    failed_tests = 0;
    fill_table();
    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;
    // STATUS still at its reset value here
    err_before = errors;
    check_registers();
    report_test(0, "register access", err_before);
    for (int r = 0; r < NROWS; r++) begin
      err_before = errors;
      run_row(r);
      report_test(r + 1, row_name[r], err_before);
    end
    $display("summary: %0d tests run, %0d with errors, %0d checks, %0d mismatches",
             NROWS + 1, failed_tests, checks, errors);
    if ((errors != 0) || timed_out) begin
      $display("tests failed");
    end else begin
      $display("all tests passed");
    end
    $finish;
  end

endmodule

/* tb_checker.sv */
// Bus monitor for the LCM accelerator testbench
// Shadow registers built from observed writes, reference LCM model
// Compares every read and the ack timing, counts mismatches
`timescale 1ns/1ps

module tb_checker (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [lcm_pkg::WB_AW-1:0] wb_adr,
  input  logic [lcm_pkg::WB_DW-1:0] wb_dat_w,
  input  logic                      wb_ack,
  input  logic [lcm_pkg::WB_DW-1:0] wb_dat_r,
  output int                        errors,
  output int                        checks
);

  import lcm_pkg::*;

  // Shadow copy of the register map
  logic [15:0]      mod_m;
  logic [3:0]       size_m;
  logic [15:0]      a_m   [VEC_MAX];
  logic [15:0]      b_m   [VEC_MAX];
  logic [31:0]      res_m [VEC_MAX];
  // 0 no run yet, 1 just started, 2 running, 3 finished
  int               run_phase;
  // Request as seen on the cycle the slave takes it
  logic             req_pending;
  logic             req_we;
  logic [WB_AW-1:0] req_adr;
  logic [WB_DW-1:0] req_dat;

  ////////////////////
  // Reference model
  function automatic logic [31:0] lcm_ref(input logic [15:0] a, input logic [15:0] b,
                                          input logic [15:0] m);
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] t;
    logic [31:0] l;
    l = '0;
    // Zero operand gives zero
    if ((a != 16'h0) && (b != 16'h0)) begin
      x = 32'(a);
      y = 32'(b);
      // Euclid
      while (y != 32'h0) begin
        t = x % y;
        x = y;
        y = t;
      end
      l = (32'(a) / x) * 32'(b);
    end
    if (m != 16'h0) begin
      l = l % 32'(m);
    end
    return l;
  endfunction

  function automatic logic [31:0] expected_read(input logic [WB_AW-1:0] adr);
    logic [31:0] e;
    e = '0;
    if ((adr >= ADDR_A_BASE) && (adr < ADDR_A_BASE + 8'(VEC_MAX))) begin
      e = {16'h0, a_m[adr[2:0]]};
    end else if ((adr >= ADDR_B_BASE) && (adr < ADDR_B_BASE + 8'(VEC_MAX))) begin
      e = {16'h0, b_m[adr[2:0]]};
    end else if ((adr >= ADDR_RES_BASE) && (adr < ADDR_RES_BASE + 8'(VEC_MAX))) begin
      e = res_m[adr[2:0]];
    end else if (adr == ADDR_MODULO) begin
      e = {16'h0, mod_m};
    end else if (adr == ADDR_SIZE) begin
      e = {28'h0, size_m};
    end
    return e;
  endfunction

  // Busy then done, never both
  function automatic logic [31:0] expected_status(input logic [31:0] seen);
    case (run_phase)
      0:       return 32'h0;
      1:       return 32'h1;
      3:       return 32'h2;
      default: return (seen == 32'h2) ? 32'h2 : 32'h1;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s: expected 0x%08h, got 0x%08h", $time, name, exp, got);
    end
  endtask

  // Size 0 runs one element, sizes past the buffer are clipped
  task automatic apply_start();
    int n;
    n = (size_m == 4'h0) ? 1 : ((size_m > 4'(VEC_MAX)) ? VEC_MAX : int'(size_m));
    for (int i = 0; i < n; i++) begin
      res_m[i] = lcm_ref(a_m[i], b_m[i], mod_m);
    end
    run_phase = 1;
  endtask

  ////////////////////
  // Bus snooping
  always @(posedge CLK) begin
    if (RST) begin
      mod_m       = '0;
      size_m      = '0;
      run_phase   = 0;
      errors      = 0;
      checks      = 0;
      req_pending = 1'b0;
      for (int i = 0; i < VEC_MAX; i++) begin
        a_m[i]   = '0;
        b_m[i]   = '0;
        res_m[i] = '0;
      end
    end else begin
      // Ack exactly one cycle after each request
      if (req_pending || wb_ack) begin
        compare("wb_ack", 32'(req_pending), 32'(wb_ack));
      end
      if (wb_ack && req_we) begin
        if ((req_adr >= ADDR_A_BASE) && (req_adr < ADDR_A_BASE + 8'(VEC_MAX))) begin
          a_m[req_adr[2:0]] = req_dat[15:0];
        end else if ((req_adr >= ADDR_B_BASE) && (req_adr < ADDR_B_BASE + 8'(VEC_MAX))) begin
          b_m[req_adr[2:0]] = req_dat[15:0];
        end else if (req_adr == ADDR_MODULO) begin
          mod_m = req_dat[15:0];
        end else if (req_adr == ADDR_SIZE) begin
          size_m = req_dat[3:0];
        end else if ((req_adr == ADDR_CTRL) && req_dat[0]) begin
          apply_start();
        end
      end else if (wb_ack && (req_adr == ADDR_STATUS)) begin
        compare("wb_dat_r (STATUS)", expected_status(wb_dat_r), wb_dat_r);
        if (run_phase == 1) begin
          run_phase = 2;
        end else if ((run_phase == 2) && (wb_dat_r == 32'h2)) begin
          run_phase = 3;
        end
      end else if (wb_ack) begin
        compare($sformatf("wb_dat_r (adr 0x%02h)", req_adr), expected_read(req_adr), wb_dat_r);
      end
      // Capture a new request
      req_pending = wb_cyc && wb_stb && !wb_ack;
      if (req_pending) begin
        req_we  = wb_we;
        req_adr = wb_adr;
        req_dat = wb_dat_w;
      end
    end
  end

endmodule

/* lcm_top.sv */
// Top level of the vector LCM accelerator
// Register block joined to the vector engine
`timescale 1ns/1ps

module lcm_top (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [lcm_pkg::WB_AW-1:0] wb_adr,
  input  logic [lcm_pkg::WB_DW-1:0] wb_dat_w,
  input  logic [3:0]                wb_sel,
  output logic                      wb_ack,
  output logic [lcm_pkg::WB_DW-1:0] wb_dat_r
);

  import lcm_pkg::*;

  // Engine links
  logic             start;
  logic             busy;
  logic             done;
  logic [IDX_W-1:0] idx;
  lcm_cfg_t         cfg;
  lcm_operand_t     op;
  lcm_result_t      res;

  lcm_regs u_regs (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .start    (start),
    .cfg      (cfg),
    .idx      (idx),
    .op       (op),
    .res      (res),
    .busy     (busy),
    .done     (done)
  );

  vector_lcm u_vector_lcm (
    .CLK   (CLK),
    .RST   (RST),
    .start (start),
    .cfg   (cfg),
    .op    (op),
    .idx   (idx),
    .res   (res),
    .busy  (busy),
    .done  (done)
  );

endmodule

/* lcm_regs.sv */
// Wishbone classic register block
// Control, status, modulus and size registers
// Operand buffers A and B, result buffer
`timescale 1ns/1ps

module lcm_regs (
  input  logic                       CLK,
  input  logic                       RST,
  // Wishbone slave
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [lcm_pkg::WB_AW-1:0]  wb_adr,
  input  logic [lcm_pkg::WB_DW-1:0]  wb_dat_w,
  // Byte enables accepted, every write stores the full word
  input  logic [3:0]                 wb_sel,
  output logic                       wb_ack,
  output logic [lcm_pkg::WB_DW-1:0]  wb_dat_r,
  // Vector engine side
  output logic                       start,
  output lcm_pkg::lcm_cfg_t          cfg,
  input  logic [lcm_pkg::IDX_W-1:0]  idx,
  output lcm_pkg::lcm_operand_t      op,
  input  lcm_pkg::lcm_result_t       res,
  input  logic                       busy,
  input  logic                       done
);

  import lcm_pkg::*;

  logic              req;
  logic              wr_en;
  logic [IDX_W-1:0]  sub;
  logic              hit_a;
  logic              hit_b;
  logic              hit_r;
  logic [WB_DW-1:0]  rd_data;

  logic [OP_W-1:0]   modulo_q;
  logic [SIZE_W-1:0] size_q;
  logic              done_q;
  logic [OP_W-1:0]   a_mem   [VEC_MAX];
  logic [OP_W-1:0]   b_mem   [VEC_MAX];
  logic [RES_W-1:0]  res_mem [VEC_MAX];

  ////////////////////
  // Decode
  // New request only when no ack is pending
  assign req   = wb_cyc && wb_stb && !wb_ack;
  assign wr_en = req && wb_we;
  assign sub   = wb_adr[IDX_W-1:0];
  assign hit_a = wb_adr[WB_AW-1:IDX_W] == ADDR_A_BASE[WB_AW-1:IDX_W];
  assign hit_b = wb_adr[WB_AW-1:IDX_W] == ADDR_B_BASE[WB_AW-1:IDX_W];
  assign hit_r = wb_adr[WB_AW-1:IDX_W] == ADDR_RES_BASE[WB_AW-1:IDX_W];

  // Read mux, unmapped words read zero
  always_comb begin
    rd_data = '0;
    if (hit_a) begin
      rd_data = WB_DW'(a_mem[sub]);
    end else if (hit_b) begin
      rd_data = WB_DW'(b_mem[sub]);
    end else if (hit_r) begin
      rd_data = WB_DW'(res_mem[sub]);
    end else begin
      case (wb_adr)
        ADDR_STATUS: rd_data = WB_DW'({done_q, busy});
        ADDR_MODULO: rd_data = WB_DW'(modulo_q);
        ADDR_SIZE:   rd_data = WB_DW'(size_q);
        default:     rd_data = '0;
      endcase
    end
  end

  ////////////////////
  // Registers and buffers
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack   <= 1'b0;
      start    <= 1'b0;
      done_q   <= 1'b0;
      modulo_q <= '0;
      size_q   <= '0;
      for (int i = 0; i < VEC_MAX; i++) begin
        a_mem[i]   <= '0;
        b_mem[i]   <= '0;
        res_mem[i] <= '0;
      end
    end else begin
      wb_ack <= req;
      // Start pulse lands on the ack cycle
      start  <= wr_en && (wb_adr == ADDR_CTRL) && wb_dat_w[0] && !busy;
      // Sticky done
      if (start) begin
        done_q <= 1'b0;
      end else if (done) begin
        done_q <= 1'b1;
      end
      if (wr_en) begin
        if (hit_a) begin
          a_mem[sub] <= wb_dat_w[OP_W-1:0];
        end else if (hit_b) begin
          b_mem[sub] <= wb_dat_w[OP_W-1:0];
        end else if (wb_adr == ADDR_MODULO) begin
          modulo_q <= wb_dat_w[OP_W-1:0];
        end else if (wb_adr == ADDR_SIZE) begin
          size_q <= wb_dat_w[SIZE_W-1:0];
        end
      end
      // Engine results
      if (res.valid) begin
        res_mem[res.idx] <= res.value;
      end
    end
  end

  // Read data captured with the ack
  always_ff @(posedge CLK) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  assign cfg = '{modulo: modulo_q, size: size_q};
  assign op  = '{a: a_mem[idx], b: b_mem[idx]};

  // Run requests only reach an idle engine
  assert property (@(posedge CLK) disable iff (RST) start |-> !busy)
    else $error("lcm_regs start while the engine is busy");

endmodule

/* vector_lcm.sv */
// Vector engine stepping through the operand buffers
// Drives one scalar LCM at a time and emits one result per element
`timescale 1ns/1ps

module vector_lcm (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  input  lcm_pkg::lcm_cfg_t          cfg,
  input  lcm_pkg::lcm_operand_t      op,
  output logic [lcm_pkg::IDX_W-1:0]  idx,
  output lcm_pkg::lcm_result_t       res,
  output logic                       busy,
  output logic                       done
);

  import lcm_pkg::*;

  vec_state_e         state;
  logic [IDX_W-1:0]   idx_q;
  logic [IDX_W-1:0]   last_idx;
  logic [SIZE_W-1:0]  eff_size;

  // Scalar engine handshake
  logic               lcm_start;
  logic               lcm_ready;
  logic [RES_W-1:0]   lcm_value;
  logic [OP_W-1:0]    a_q;
  logic [OP_W-1:0]    b_q;

  // Result fields
  logic               res_valid;
  logic [IDX_W-1:0]   res_idx;
  logic [RES_W-1:0]   res_value;

  // Size 0 runs one element, large sizes clip to the buffer
  always_comb begin
    if (cfg.size == '0) begin
      eff_size = SIZE_W'(1);
    end else if (cfg.size > SIZE_W'(VEC_MAX)) begin
      eff_size = SIZE_W'(VEC_MAX);
    end else begin
      eff_size = cfg.size;
    end
  end

  assign last_idx = IDX_W'(eff_size - SIZE_W'(1));

  ////////////////////
  // Element sequencing
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= VEC_IDLE;
      idx_q     <= '0;
      lcm_start <= 1'b0;
      res_valid <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else begin
      lcm_start <= 1'b0;
      res_valid <= 1'b0;
      done      <= 1'b0;
      // Busy drops one cycle after the last result
      if (done) begin
        busy <= 1'b0;
      end
      case (state)
        VEC_IDLE: begin
          if (start && !busy) begin
            idx_q <= '0;
            busy  <= 1'b1;
            state <= VEC_LOAD;
          end
        end
        VEC_LOAD: begin
          lcm_start <= 1'b1;
          state     <= VEC_WAIT;
        end
        VEC_WAIT: begin
          if (lcm_ready) begin
            res_valid <= 1'b1;
            if (idx_q == last_idx) begin
              done  <= 1'b1;
              state <= VEC_IDLE;
            end else begin
              idx_q <= idx_q + IDX_W'(1);
              state <= VEC_LOAD;
            end
          end
        end
        default: state <= VEC_IDLE;
      endcase
    end
  end

  ////////////////////
  // Operand and result capture
  always_ff @(posedge CLK) begin
    if (state == VEC_LOAD) begin
      a_q <= op.a;
      b_q <= op.b;
    end
    if ((state == VEC_WAIT) && lcm_ready) begin
      res_idx   <= idx_q;
      res_value <= lcm_value;
    end
  end

  assign idx = idx_q;
  assign res = '{valid: res_valid, idx: res_idx, value: res_value};

  scalar_lcm u_scalar_lcm (
    .CLK    (CLK),
    .RST    (RST),
    .start  (lcm_start),
    .a      (a_q),
    .b      (b_q),
    .modulo (cfg.modulo),
    .ready  (lcm_ready),
    .value  (lcm_value)
  );

  // Results belong to a run
  assert property (@(posedge CLK) disable iff (RST) res.valid |-> busy)
    else $error("vector_lcm result outside a run");

endmodule

/* scalar_lcm.sv */
// LCM of one operand pair reduced by a modulus
// GCD, then restoring divide, shift-add multiply and restoring remainder
`timescale 1ns/1ps

module scalar_lcm (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  logic [lcm_pkg::OP_W-1:0]  a,
  input  logic [lcm_pkg::OP_W-1:0]  b,
  input  logic [lcm_pkg::OP_W-1:0]  modulo,
  output logic                      ready,
  output logic [lcm_pkg::RES_W-1:0] value
);

  import lcm_pkg::*;

  lcm_state_e       state;
  logic [4:0]       cnt;
  logic             gcd_start;
  logic             gcd_ready;
  logic [OP_W-1:0]  gcd_value;

  // Latched operands and arithmetic registers
  logic [OP_W-1:0]  a_q;
  logic [OP_W-1:0]  b_q;
  logic [OP_W-1:0]  mod_q;
  logic [OP_W-1:0]  g_q;
  logic [OP_W-1:0]  quo;
  logic [OP_W-1:0]  rem;
  logic [RES_W-1:0] prod;

  // Shared restoring step for DIV and MOD
  logic [OP_W-1:0]  divisor;
  logic             shift_in;
  logic [OP_W:0]    rem_sh;
  logic             fits;
  logic [OP_W-1:0]  rem_next;
  logic [RES_W-1:0] prod_next;

  assign divisor  = (state == LCM_MOD) ? mod_q : g_q;
  assign shift_in = (state == LCM_MOD) ? prod[RES_W-1] : quo[OP_W-1];
  assign rem_sh   = {rem, shift_in};
  assign fits     = rem_sh >= {1'b0, divisor};
  assign rem_next = fits ? OP_W'(rem_sh - {1'b0, divisor}) : rem_sh[OP_W-1:0];

  // MSB first shift-add of quotient times b
  assign prod_next = {prod[RES_W-2:0], 1'b0} + (quo[OP_W-1] ? RES_W'(b_q) : '0);

  scalar_gcd u_gcd (
    .CLK   (CLK),
    .RST   (RST),
    .start (gcd_start),
    .a     (a_q),
    .b     (b_q),
    .ready (gcd_ready),
    .gcd   (gcd_value)
  );

  ////////////////////
  // Phase sequencing
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= LCM_IDLE;
      cnt       <= '0;
      gcd_start <= 1'b0;
      ready     <= 1'b0;
    end else begin
      gcd_start <= 1'b0;
      ready     <= 1'b0;
      case (state)
        LCM_IDLE: begin
          if (start) begin
            if ((a == '0) || (b == '0)) begin
              state <= LCM_DONE;
            end else begin
              gcd_start <= 1'b1;
              state     <= LCM_GCD;
            end
          end
        end
        LCM_GCD: begin
          cnt <= '0;
          if (gcd_ready) begin
            state <= LCM_DIV;
          end
        end
        LCM_DIV: begin
          cnt <= cnt + 5'd1;
          if (cnt == 5'(OP_W - 1)) begin
            cnt   <= '0;
            state <= LCM_MUL;
          end
        end
        LCM_MUL: begin
          cnt <= cnt + 5'd1;
          if (cnt == 5'(OP_W - 1)) begin
            cnt   <= '0;
            // No reduction for a zero modulus
            state <= (mod_q == '0) ? LCM_DONE : LCM_MOD;
          end
        end
        LCM_MOD: begin
          cnt <= cnt + 5'd1;
          if (cnt == 5'(RES_W - 1)) begin
            state <= LCM_DONE;
          end
        end
        LCM_DONE: begin
          ready <= 1'b1;
          state <= LCM_IDLE;
        end
        default: state <= LCM_IDLE;
      endcase
    end
  end

  ////////////////////
  // Arithmetic
  always_ff @(posedge CLK) begin
    case (state)
      LCM_IDLE: begin
        if (start) begin
          a_q   <= a;
          b_q   <= b;
          mod_q <= modulo;
          // Zero operand result
          value <= '0;
        end
      end
      LCM_GCD: begin
        g_q <= gcd_value;
        quo <= a_q;
        rem <= '0;
      end
      LCM_DIV: begin
        rem  <= rem_next;
        quo  <= {quo[OP_W-2:0], fits};
        prod <= '0;
      end
      LCM_MUL: begin
        prod <= prod_next;
        quo  <= quo << 1;
        rem  <= '0;
        value <= prod_next;
      end
      LCM_MOD: begin
        rem   <= rem_next;
        prod  <= prod << 1;
        value <= RES_W'(rem_next);
      end
      default: ;
    endcase
  end

  // Requests only arrive between operations
  assert property (@(posedge CLK) disable iff (RST) start |-> state == LCM_IDLE)
    else $error("scalar_lcm start outside IDLE");

endmodule

/* scalar_gcd.sv */
// Iterative binary GCD of two operands
// One reduction step per cycle, ready pulses with the result
`timescale 1ns/1ps

module scalar_gcd (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  logic [lcm_pkg::OP_W-1:0] a,
  input  logic [lcm_pkg::OP_W-1:0] b,
  output logic                     ready,
  output logic [lcm_pkg::OP_W-1:0] gcd
);

  import lcm_pkg::*;

  // Working pair and count of shared factors of two
  logic [OP_W-1:0] x;
  logic [OP_W-1:0] y;
  logic [3:0]      k;
  logic            busy;
  logic            launch;

  assign launch = start && !busy;

  ////////////////////
  // Control
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (launch) begin
        // Zero operand finishes at once
        busy  <= (a != '0) && (b != '0);
        ready <= (a == '0) || (b == '0);
      end else if (busy && (x == y)) begin
        busy  <= 1'b0;
        ready <= 1'b1;
      end
    end
  end

  ////////////////////
  // Datapath
  always_ff @(posedge CLK) begin
    if (launch) begin
      x   <= a;
      y   <= b;
      k   <= '0;
      // Other operand when one is zero
      gcd <= a | b;
    end else if (busy) begin
      if (x == y) begin
        // Put the common twos back
        gcd <= x << k;
      end else if (!x[0] && !y[0]) begin
        x <= x >> 1;
        y <= y >> 1;
        k <= k + 4'd1;
      end else if (!x[0]) begin
        x <= x >> 1;
      end else if (!y[0]) begin
        y <= y >> 1;
      end else if (x > y) begin
        // Both odd so the difference is even
        x <= (x - y) >> 1;
      end else begin
        y <= (y - x) >> 1;
      end
    end
  end

  // Result strobe is a single pulse per request
  assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else $error("scalar_gcd ready held for two cycles");

endmodule

/* lcm_pkg.sv */
// Widths and word addresses of the LCM accelerator
// FSM state enums for the vector and scalar engines
// Packed structs passed between register block and engine
package lcm_pkg;

  ////////////////////
  // Widths
  localparam int OP_W    = 16;
  localparam int RES_W   = 32;
  localparam int VEC_MAX = 8;
  localparam int IDX_W   = 3;
  localparam int SIZE_W  = 4;
  localparam int WB_AW   = 8;
  localparam int WB_DW   = 32;

  ////////////////////
  // Word addresses of the register map
  localparam logic [WB_AW-1:0] ADDR_CTRL     = 8'h00;
  localparam logic [WB_AW-1:0] ADDR_STATUS   = 8'h01;
  localparam logic [WB_AW-1:0] ADDR_MODULO   = 8'h02;
  localparam logic [WB_AW-1:0] ADDR_SIZE     = 8'h03;
  localparam logic [WB_AW-1:0] ADDR_A_BASE   = 8'h10;
  localparam logic [WB_AW-1:0] ADDR_B_BASE   = 8'h20;
  localparam logic [WB_AW-1:0] ADDR_RES_BASE = 8'h30;

  ////////////////////
  // FSM states
  typedef enum logic [1:0] {VEC_IDLE, VEC_LOAD, VEC_WAIT} vec_state_e;

  typedef enum logic [2:0] {
    LCM_IDLE, LCM_GCD, LCM_DIV, LCM_MUL, LCM_MOD, LCM_DONE
  } lcm_state_e;

  ////////////////////
  // Block to block bundles
  typedef struct packed {
    logic [OP_W-1:0]   modulo;
    logic [SIZE_W-1:0] size;
  } lcm_cfg_t;

  typedef struct packed {
    logic [OP_W-1:0] a;
    logic [OP_W-1:0] b;
  } lcm_operand_t;

  typedef struct packed {
    logic             valid;
    logic [IDX_W-1:0] idx;
    logic [RES_W-1:0] value;
  } lcm_result_t;

endpackage
